//--- trace_capture_defs.svh
`ifndef TRACE_CAPTURE_DEFS_SVH
`define TRACE_CAPTURE_DEFS_SVH

// one raw adc sample, as delivered by the converter
`define SAMPLE_WIDTH 12

// default capture fifo depth, must stay a power of two
`define FIFO_DEPTH 32

// sample count and fill threshold registers
`define CNT_WIDTH 16

// four host registers, word addressed
`define REG_AW 2

`endif

//--- trace_capture_pkg.sv
`default_nettype none
`include "trace_capture_defs.svh"

package trace_capture_pkg;

  // host register map
  typedef enum logic [`REG_AW-1:0] {
    REG_CTRL   = 2'd0,  // bit 0 arms a capture
    REG_COUNT  = 2'd1,  // samples per capture
    REG_THRESH = 2'd2,  // fifo fill threshold
    REG_STATUS = 2'd3   // read only
  } reg_addr_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,    // waiting for trigger
    ST_CAPTURE   // forwarding samples into the fifo
  } cap_state_e;

  typedef struct packed {
    logic        wr;
    logic        rd;
    reg_addr_e   addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } reg_rsp_t;

  // one fifo entry; first marks the sample right after the trigger
  typedef struct packed {
    logic                     first;
    logic [`SAMPLE_WIDTH-1:0] data;
  } sample_word_t;

  typedef struct packed {
    logic                  arm;        // single cycle
    logic [`CNT_WIDTH-1:0] count;
    logic [`CNT_WIDTH-1:0] threshold;
  } cap_cfg_t;

  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic full;
    logic threshold;
    logic overflow;   // pulse
    logic underflow;  // pulse
  } fifo_stat_t;

endpackage

`default_nettype wire

//--- capture_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "trace_capture_defs.svh"

module capture_regs (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire trace_capture_pkg::reg_req_t   reg_req,    // one access per cycle
  output trace_capture_pkg::reg_rsp_t        reg_rsp,    // reply one cycle after rd
  output trace_capture_pkg::cap_cfg_t        cfg,
  input  wire logic                          busy,
  input  wire logic                          cap_done,
  input  wire trace_capture_pkg::fifo_stat_t fifo_stat
);
  import trace_capture_pkg::*;

  logic                  arm_q;        // arm pulse towards the controller
  logic [`CNT_WIDTH-1:0] count_q;
  logic [`CNT_WIDTH-1:0] thresh_q;
  logic                  done_q;       // sticky
  logic                  ovf_q;        // sticky
  logic                  rsp_valid_q;
  logic [31:0]           rsp_data_q;
  logic [31:0]           status;
  logic [31:0]           rd_mux;
  logic                  wr_ctrl;
  logic                  wr_count;
  logic                  wr_thresh;

  // write decode
  assign wr_ctrl   = reg_req.wr && (reg_req.addr == REG_CTRL);
  assign wr_count  = reg_req.wr && (reg_req.addr == REG_COUNT);
  assign wr_thresh = reg_req.wr && (reg_req.addr == REG_THRESH);

  // status word, upper bits read as zero
  assign status = {26'd0,
                   fifo_stat.threshold,  // bit 5, live
                   fifo_stat.full,       // bit 4, live
                   fifo_stat.empty,      // bit 3, live
                   ovf_q,                // bit 2
                   done_q,               // bit 1
                   busy};                // bit 0

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arm_q       <= 1'b0;
      count_q     <= '0;
      thresh_q    <= '0;
      done_q      <= 1'b0;
      ovf_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      arm_q <= wr_ctrl && reg_req.wdata[0];  // self clearing
      if (wr_count)
        count_q <= reg_req.wdata[`CNT_WIDTH-1:0];
      if (wr_thresh)
        thresh_q <= reg_req.wdata[`CNT_WIDTH-1:0];
      // a new arm starts a fresh capture record
      if (arm_q)
        done_q <= 1'b0;
      else if (cap_done)
        done_q <= 1'b1;
      if (arm_q)
        ovf_q <= 1'b0;
      else if (fifo_stat.overflow)
        ovf_q <= 1'b1;
      rsp_valid_q <= reg_req.rd;
    end
  end

  // read mux
  always_comb begin
    unique case (reg_req.addr)
      REG_CTRL:   rd_mux = 32'(busy);      // arm bit reads back as busy
      REG_COUNT:  rd_mux = 32'(count_q);
      REG_THRESH: rd_mux = 32'(thresh_q);
      REG_STATUS: rd_mux = status;
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reg_req.rd)
      rsp_data_q <= rd_mux;  // captured with the request, held until the next read
  end

  assign cfg     = '{arm: arm_q, count: count_q, threshold: thresh_q};
  assign reg_rsp = '{valid: rsp_valid_q, rdata: rsp_data_q};

  // reply only ever follows a read request by exactly one cycle
  a_rsp_after_rd: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rsp.valid |-> $past(reg_req.rd));

endmodule

`default_nettype wire

//--- capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "trace_capture_defs.svh"

module capture_ctrl (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire trace_capture_pkg::cap_cfg_t   cfg,
  input  wire logic [`SAMPLE_WIDTH-1:0]      adc_sample,
  input  wire logic                          sample_valid,  // no back-pressure
  input  wire logic                          trigger,       // level, sampled each cycle
  output logic                               wr_valid,
  output trace_capture_pkg::sample_word_t    wr_word,
  output logic                               busy,
  output logic                               cap_done
);
  import trace_capture_pkg::*;

  cap_state_e            state_q;
  logic [`CNT_WIDTH-1:0] remain_q;  // writes still to issue
  logic                  first_q;   // next write is the first after trigger
  logic                  last_wr;

  // samples go straight to the fifo write port
  assign wr_valid = (state_q == ST_CAPTURE) && sample_valid;
  assign wr_word  = '{first: first_q, data: adc_sample};
  assign busy     = (state_q != ST_IDLE);
  assign last_wr  = wr_valid && (remain_q == `CNT_WIDTH'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ST_IDLE;
      remain_q <= '0;
      first_q  <= 1'b0;
      cap_done <= 1'b0;
    end else begin
      cap_done <= 1'b0;  // pulse
      unique case (state_q)
        ST_IDLE: begin
          if (cfg.arm) begin
            remain_q <= cfg.count;
            // zero length capture finishes without waiting for a trigger
            if (cfg.count == '0)
              cap_done <= 1'b1;
            else
              state_q <= ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (trigger) begin
            state_q <= ST_CAPTURE;
            first_q <= 1'b1;
          end
        end
        ST_CAPTURE: begin
          // every valid sample counts, stored or dropped
          if (wr_valid) begin
            remain_q <= remain_q - `CNT_WIDTH'(1);
            first_q  <= 1'b0;
            if (last_wr) begin
              state_q  <= ST_IDLE;
              cap_done <= 1'b1;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // counter never runs out while writes are still going out
  a_wr_in_capture: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid |-> (state_q == ST_CAPTURE) && (remain_q != '0));

  // done comes with the return to idle
  a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cap_done |-> !busy);

endmodule

`default_nettype wire

//--- sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "trace_capture_defs.svh"

module sample_fifo #(
  parameter int DEPTH = `FIFO_DEPTH  // power of two of at least 4
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic [`CNT_WIDTH-1:0]           threshold,
  input  wire logic                            wr_valid,
  input  wire trace_capture_pkg::sample_word_t wr_word,
  output logic                                 wr_ready,
  output logic                                 out_valid,
  output trace_capture_pkg::sample_word_t      out_word,
  input  wire logic                            out_ready,
  output trace_capture_pkg::fifo_stat_t        stat
);
  import trace_capture_pkg::*;

  localparam int AW = $clog2(DEPTH);

  if ((DEPTH < 4) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
    $error("sample_fifo DEPTH must be a power of two of at least 4");
  end

  sample_word_t mem [DEPTH];  // flop storage
  logic [AW:0]  wptr_q;       // extra msb tells full from empty
  logic [AW:0]  rptr_q;
  logic [AW:0]  fill;
  logic [AW:0]  thresh_trim;
  logic         full;
  logic         empty;
  logic         wr_fire;
  logic         rd_fire;
  logic         ovf_q;
  logic         udf_q;

  // same address on a different lap
  assign full  = (wptr_q[AW] != rptr_q[AW]) && (wptr_q[AW-1:0] == rptr_q[AW-1:0]);
  assign empty = (wptr_q == rptr_q);

  // modulo difference of the pointers gives the fill level across the wrap
  assign fill        = wptr_q - rptr_q;
  assign thresh_trim = threshold[AW:0];

  assign wr_ready = !full;
  assign wr_fire  = wr_valid && !full;
  assign rd_fire  = out_valid && out_ready;

  // first word fall through with the head entry always on the output
  assign out_valid = !empty;
  assign out_word  = mem[rptr_q[AW-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q <= '0;
      rptr_q <= '0;
    end else begin
      if (wr_fire)
        wptr_q <= wptr_q + (AW+1)'(1);
      if (rd_fire)
        rptr_q <= rptr_q + (AW+1)'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire)
      mem[wptr_q[AW-1:0]] <= wr_word;
  end

  // one cycle pulses for refused accesses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ovf_q <= 1'b0;
      udf_q <= 1'b0;
    end else begin
      ovf_q <= wr_valid && full;  // sample dropped
      udf_q <= rd_fire && empty;
    end
  end

  assign stat = '{
    empty:        empty,
    almost_empty: (fill <= (AW+1)'(1)),
    full:         full,
    threshold:    (fill >= thresh_trim),
    overflow:     ovf_q,
    underflow:    udf_q
  };

  // neither pointer can run past the other so the fill level stays within the depth
  a_fill_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    fill <= (AW+1)'(DEPTH));

  // valid/ready read side cannot pop an empty fifo
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    !stat.underflow);

endmodule

`default_nettype wire

//--- trace_capture_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "trace_capture_defs.svh"

module trace_capture_top (
  input  wire logic                          clk,
  input  wire logic                          rst_n,
  input  wire trace_capture_pkg::reg_req_t   reg_req,
  output trace_capture_pkg::reg_rsp_t        reg_rsp,
  input  wire logic [`SAMPLE_WIDTH-1:0]      adc_sample,
  input  wire logic                          sample_valid,
  input  wire logic                          trigger,
  output logic                               out_valid,
  output trace_capture_pkg::sample_word_t    out_word,
  input  wire logic                          out_ready
);
  import trace_capture_pkg::*;

  cap_cfg_t     cfg;        // arm, count, threshold
  logic         busy;
  logic         cap_done;
  fifo_stat_t   fifo_stat;
  logic         wr_valid;
  sample_word_t wr_word;

  capture_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_req   (reg_req),
    .reg_rsp   (reg_rsp),
    .cfg       (cfg),
    .busy      (busy),
    .cap_done  (cap_done),
    .fifo_stat (fifo_stat)
  );

  capture_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .adc_sample   (adc_sample),
    .sample_valid (sample_valid),
    .trigger      (trigger),
    .wr_valid     (wr_valid),
    .wr_word      (wr_word),
    .busy         (busy),
    .cap_done     (cap_done)
  );

  // adc cannot stall, drops show up as overflow in the status
  sample_fifo #(
    .DEPTH (`FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .threshold (cfg.threshold),
    .wr_valid  (wr_valid),
    .wr_word   (wr_word),
    .wr_ready  (),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_ready (out_ready),
    .stat      (fifo_stat)
  );

endmodule

`default_nettype wire

//--- tb_trace_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "trace_capture_defs.svh"

module tb_trace_capture;
  import trace_capture_pkg::*;

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int TMO   = 200;  // limit for every wait loop

  logic                     clk;
  logic                     rst_n;
  reg_req_t                 reg_req;
  reg_rsp_t                 reg_rsp;
  logic [`SAMPLE_WIDTH-1:0] adc_sample;
  logic                     sample_valid;
  logic                     trigger;
  logic                     out_valid;
  sample_word_t             out_word;
  logic                     out_ready;

  logic [15:0]           lfsr;
  sample_word_t          exp_q[$];      // words the fifo should hold in arrival order
  int                    ready_mode;    // 0 stalls, 1 is always ready and 2 follows the lfsr
  int                    rx_left;       // pops still allowed
  int                    rx_count;
  bit                    popped;        // a pop lands on the coming edge
  int                    errors;
  int                    checks;
  int                    tests;
  logic [`CNT_WIDTH-1:0] thresh_model;
  bit                    done_model;    // sticky bits as the host should see them
  bit                    ovf_model;

  trace_capture_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .reg_req      (reg_req),
    .reg_rsp      (reg_rsp),
    .adc_sample   (adc_sample),
    .sample_valid (sample_valid),
    .trigger      (trigger),
    .out_valid    (out_valid),
    .out_word     (out_word),
    .out_ready    (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr stepped once per bit handed out
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 16'hB400;
    return b;
  endfunction

  function automatic logic [`SAMPLE_WIDTH-1:0] rand_sample();
    logic [`SAMPLE_WIDTH-1:0] v;
    v = '0;
    for (int i = 0; i < `SAMPLE_WIDTH; i++)
      v = {v[`SAMPLE_WIDTH-2:0], next_bit()};
    return v;
  endfunction

  // status word predicted from the register map and the fill level
  function automatic logic [31:0] status_word(input logic busy, input int fill);
    logic [31:0] s;
    s    = '0;
    s[0] = busy;
    s[1] = done_model;
    s[2] = ovf_model;
    s[3] = (fill == 0);
    s[4] = (fill == DEPTH);
    s[5] = (fill >= (int'(thresh_model) % (2 * DEPTH)));  // threshold trimmed to aw+1 bits
    return s;
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic check_word(input sample_word_t got, input sample_word_t exp,
                            input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s expected first=%0b data=0x%03h got first=%0b data=0x%03h",
               $time, name, exp.first, exp.data, got.first, got.data);
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp,
                              input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s expected %0b got %0b", $time, name, exp, got);
    end
  endtask

  // one clock with inputs driven 2 ns after the edge and the stream side served every cycle
  task automatic step();
    @(posedge clk);
    #2;
    popped    = 1'b0;
    out_ready = 1'b0;
    if (rx_left > 0) begin
      if (ready_mode == 1)
        out_ready = 1'b1;
      else if (ready_mode == 2)
        out_ready = next_bit();
    end
    if (out_valid && out_ready) begin  // word leaves on the next edge
      popped = 1'b1;
      rx_count++;
      rx_left--;
      if (exp_q.size() == 0)
        note_error("stream delivered a word that was never captured");
      else
        check_word(out_word, exp_q.pop_front(), "out_word");
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
    reg_req.wr    = 1'b1;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    step();
    reg_req.wr = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e addr, output logic [31:0] data);
    int n;
    reg_req.rd   = 1'b1;
    reg_req.addr = addr;
    step();
    reg_req.rd = 1'b0;
    check_flag(reg_rsp.valid, 1'b1, "reg_rsp.valid one cycle after rd");
    n = 0;
    while (!reg_rsp.valid && n < TMO) begin
      step();
      n++;
    end
    data = reg_rsp.rdata;
    if (!reg_rsp.valid) begin
      note_error("register read got no reply");
      data = 'x;
    end else begin
      step();
      check_flag(reg_rsp.valid, 1'b0, "reg_rsp.valid after reply");  // single cycle reply
    end
  endtask

  // poll the status register until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] val,
                             input string what);
    logic [31:0] s;
    int          n;
    n = 0;
    reg_read(REG_STATUS, s);
    while (((s & mask) !== val) && n < TMO) begin
      reg_read(REG_STATUS, s);
      n++;
    end
    if ((s & mask) !== val)
      note_error({"timed out waiting for ", what});
  endtask

  task automatic start_capture(input int count);
    reg_write(REG_COUNT, 32'(count));
    reg_write(REG_CTRL, 32'd1);
    done_model = 1'b0;  // arm clears both sticky bits
    ovf_model  = 1'b0;
    wait_status(32'h1, 32'h1, "busy after arm");
    trigger = 1'b1;
    step();             // trigger seen while armed
    trigger = 1'b0;
  endtask

  task automatic send_samples(input int n);
    sample_word_t w;
    for (int i = 0; i < n; i++) begin
      w.first      = (i == 0);
      w.data       = rand_sample();
      adc_sample   = w.data;
      sample_valid = 1'b1;
      if (exp_q.size() + int'(popped) < DEPTH)  // fill before the edge decides
        exp_q.push_back(w);
      else
        ovf_model = 1'b1;                        // dropped
      step();
    end
    sample_valid = 1'b0;
    done_model   = 1'b1;
    wait_status(32'h3, 32'h2, "capture done");
  endtask

  task automatic drain_all(input int mode);
    int n;
    n          = 0;
    ready_mode = mode;
    rx_left    = 1000;
    while ((exp_q.size() != 0 || out_valid) && n < TMO) begin
      step();
      n++;
    end
    if (exp_q.size() != 0)
      note_error("stream stopped before every captured word came out");
    check_flag(out_valid, 1'b0, "out_valid after drain");
  endtask

  task automatic drain_words(input int k);
    int n;
    n          = 0;
    ready_mode = 1;
    rx_left    = k;
    while (rx_left > 0 && n < TMO) begin
      step();
      n++;
    end
    if (rx_left > 0)
      note_error("timed out draining words from the stream");
    ready_mode = 0;
    step();  // last pop lands before any status read
  endtask

  task automatic end_test(input int num, input string name, input int start_err);
    tests++;
    $display("test %0d %s finished with %0d error(s)", num, name, errors - start_err);
  endtask

  task automatic test_regs();
    logic [31:0] s;
    int          e;
    e = errors;
    reg_read(REG_STATUS, s);
    check_status(s, status_word(1'b0, 0), "status after reset");
    reg_write(REG_COUNT, 32'hABCD_0123);
    reg_write(REG_THRESH, 32'h0000_0010);
    thresh_model = 16'h0010;
    reg_read(REG_COUNT, s);
    check_status(s, 32'h0000_0123, "count read back");  // upper bits not stored
    reg_read(REG_THRESH, s);
    check_status(s, 32'h0000_0010, "threshold read back");
    end_test(1, "register access", e);
  endtask

  task automatic test_basic();
    logic [31:0] s;
    int          e;
    e          = errors;
    ready_mode = 1;
    rx_left    = 1000;
    rx_count   = 0;
    start_capture(10);
    send_samples(10);
    drain_all(1);
    if (rx_count != 10)
      note_error("basic capture returned the wrong number of words");
    reg_read(REG_STATUS, s);
    check_status(s, status_word(1'b0, 0), "status after basic capture");
    end_test(2, "basic capture", e);
  endtask

  task automatic test_stalls();
    logic [31:0] s;
    int          e;
    e          = errors;
    ready_mode = 2;
    rx_left    = 1000;
    rx_count   = 0;
    start_capture(20);
    send_samples(20);
    drain_all(2);  // keep stalling while draining
    if (rx_count != 20)
      note_error("stalled stream returned the wrong number of words");
    reg_read(REG_STATUS, s);
    check_status(s, status_word(1'b0, 0), "status after stalled capture");
    end_test(3, "stalled read side", e);
  endtask

  task automatic test_overflow();
    logic [31:0] s;
    int          e;
    e          = errors;
    ready_mode = 0;
    rx_count   = 0;
    start_capture(40);
    send_samples(40);
    reg_read(REG_STATUS, s);
    check_flag(s[4], 1'b1, "status full");
    check_flag(s[2], 1'b1, "status overflow");
    check_status(s, status_word(1'b0, exp_q.size()), "status after overflow");
    drain_all(1);
    if (rx_count != DEPTH)
      note_error("overflowed capture did not return exactly one fifo of words");
    end_test(4, "overflow", e);
  endtask

  task automatic test_unarmed();
    logic [31:0] s;
    int          e;
    e          = errors;
    ready_mode = 1;
    rx_left    = 1000;
    trigger    = 1'b1;  // nothing may happen without an arm
    for (int i = 0; i < 8; i++) begin
      adc_sample   = rand_sample();
      sample_valid = 1'b1;
      step();
      check_flag(out_valid, 1'b0, "out_valid while unarmed");
    end
    sample_valid = 1'b0;
    reg_read(REG_STATUS, s);
    check_status(s, status_word(1'b0, 0), "status while unarmed");
    trigger = 1'b0;
    reg_write(REG_COUNT, 32'd0);  // zero length capture ends at once
    reg_write(REG_CTRL, 32'd1);
    ovf_model  = 1'b0;
    done_model = 1'b1;
    wait_status(32'h7, 32'h2, "done with overflow cleared");
    reg_read(REG_STATUS, s);
    check_status(s, status_word(1'b0, 0), "status after later arm");
    end_test(6, "unarmed trigger", e);
  endtask

  task automatic test_threshold();
    logic [31:0] s;
    int          e;
    e = errors;
    reg_write(REG_THRESH, 32'd8);
    thresh_model = 16'd8;
    ready_mode   = 0;
    rx_count     = 0;
    start_capture(10);
    send_samples(10);
    reg_read(REG_STATUS, s);
    check_flag(s[5], 1'b1, "threshold flag at 10 words");
    check_status(s, status_word(1'b0, exp_q.size()), "status before partial drain");
    drain_words(3);
    reg_read(REG_STATUS, s);
    check_flag(s[5], 1'b0, "threshold flag at 7 words");
    check_status(s, status_word(1'b0, exp_q.size()), "status after partial drain");
    drain_all(1);
    if (rx_count != 10)
      note_error("threshold capture returned the wrong number of words");
    end_test(5, "threshold flag", e);
  endtask

  initial begin
    lfsr         = 16'd5;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    rx_count     = 0;
    rx_left      = 0;
    ready_mode   = 0;
    popped       = 1'b0;
    done_model   = 1'b0;
    ovf_model    = 1'b0;
    thresh_model = '0;
    rst_n        = 1'b0;
    reg_req      = '0;
    adc_sample   = '0;
    sample_valid = 1'b0;
    trigger      = 1'b0;
    out_ready    = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_regs();
    test_basic();
    test_stalls();
    test_overflow();
    test_unarmed();    // relies on the sticky overflow left by the overflow test
    test_threshold();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- trace_capture.f
+incdir+.
trace_capture_pkg.sv
capture_regs.sv
capture_ctrl.sv
sample_fifo.sv
trace_capture_top.sv
tb_trace_capture.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f trace_capture.f \
  --top-module tb_trace_capture -o sim_trace_capture
./obj_dir/sim_trace_capture | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"
